// File: Makefile
VERILATOR ?= verilator
TOP ?= video_pipe_tb
FILELIST ?= video_pipe.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "=== FAIL ===" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/video_pipe_checker.sv
// video output assertions

`timescale 1ns/1ns

`include "video_settings.svh"

module video_pipe_checker
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
(
	input logic in_clk,
	input logic in_rst,
	input logic out_hsync,
	input logic out_pixel_enable,
	input pixel_t out_pixel,
	input logic [HPIX_BITS - 1 : 0] out_hpix
);

	localparam int HSYNC_LEN = `VID_HSYNC_STOP - `VID_HSYNC_START;

	// cycles of the current hsync pulse
	int hsync_run;

	// failure tallies, summed by the testbench
	int unsigned blank_fails = 0;
	int unsigned hsync_long_fails = 0;
	int unsigned hsync_len_fails = 0;
	int unsigned hpix_fails = 0;

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			hsync_run <= 0;
		end else if (out_hsync) begin
			hsync_run <= hsync_run + 1;
		end else begin
			hsync_run <= 0;
		end
	end

	// black in blanking
	a_blank_black: assert property (@(posedge in_clk) disable iff (in_rst)
		!out_pixel_enable |-> (out_pixel == '0))
	else begin
		$error("pixel not black while pixel enable is low");
		blank_fails++;
	end

	// pulse never runs past its length
	a_hsync_bounded: assert property (@(posedge in_clk) disable iff (in_rst)
		out_hsync |-> (hsync_run < HSYNC_LEN))
	else begin
		$error("hsync pulse longer than %0d cycles", HSYNC_LEN);
		hsync_long_fails++;
	end

	// and is never cut short
	a_hsync_length: assert property (@(posedge in_clk) disable iff (in_rst)
		$fell(out_hsync) |-> (hsync_run == HSYNC_LEN))
	else begin
		$error("hsync pulse ended after %0d cycles", hsync_run);
		hsync_len_fails++;
	end

	// columns count up by one along an enabled run
	a_hpix_step: assert property (@(posedge in_clk) disable iff (in_rst)
		(out_pixel_enable && $past(out_pixel_enable))
		|-> (out_hpix == $past(out_hpix) + 1'b1))
	else begin
		$error("hpix %0d does not follow the previous column", out_hpix);
		hpix_fails++;
	end

endmodule

// attach to the pipeline top level
bind video_pipe video_pipe_checker u_checker (
	.in_clk (in_clk),
	.in_rst (in_rst),
	.out_hsync (out_hsync),
	.out_pixel_enable (out_pixel_enable),
	.out_pixel (out_pixel),
	.out_hpix (out_hpix)
);

// File: bench/video_pipe_tb.sv
// video pipeline testbench

`timescale 1ns/1ns

`include "video_settings.svh"

module video_pipe_tb
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 4;
	localparam int H_VIS = `VID_HPIX_VISIBLE;
	localparam int V_VIS = `VID_VPIX_VISIBLE;
	localparam int H_TOTAL = `VID_HPIX_TOTAL;
	localparam int FRAME_CYCLES = `VID_HPIX_TOTAL * `VID_VPIX_TOTAL;
	localparam int HSYNC_LEN = `VID_HSYNC_STOP - `VID_HSYNC_START;
	localparam int NUM_FRAMES = 4;
	localparam int NUM_WRITES = 150;
	localparam int WATCHDOG_CYCLES = FB_WORDS + NUM_FRAMES * FRAME_CYCLES + 200;
	localparam logic [31:0] SEED = 32'h50bcc256;

	logic in_clk = 1'b0;
	logic in_rst;
	logic in_testpattern;
	logic in_wr_en;
	fb_addr_t in_wr_addr;
	pixel_t in_wr_data;
	logic out_hsync;
	logic out_vsync;
	logic out_pixel_enable;
	pixel_t out_pixel;
	logic [HPIX_BITS - 1 : 0] out_hpix;
	logic [VPIX_BITS - 1 : 0] out_vpix;

	// reference copy of the frame buffer
	pixel_t model [FB_WORDS];
	logic [31:0] rng_state;
	// mode of the frame being scanned
	logic expect_pattern;

	int value_errors = 0;
	int raster_errors = 0;
	// monitor state, cycles counted from reset release
	int cycle_no = 0;
	int pix_x = 0;
	int line_y = 0;
	int vsync_rises = 0;
	int frames_done = 0;
	int pixels_done = 0;
	int last_hs_rise = -1;
	int last_vs_rise = -1;
	int hs_len = 0;
	logic prev_hsync = 1'b0;
	logic prev_vsync = 1'b0;
	logic prev_en = 1'b0;

	video_pipe u_video_pipe (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.in_testpattern (in_testpattern),
		.in_wr_en (in_wr_en),
		.in_wr_addr (in_wr_addr),
		.in_wr_data (in_wr_data),
		.out_hsync (out_hsync),
		.out_vsync (out_vsync),
		.out_pixel_enable (out_pixel_enable),
		.out_pixel (out_pixel),
		.out_hpix (out_hpix),
		.out_vpix (out_vpix)
	);

	initial begin
		forever #(CLK_PERIOD / 2) in_clk = ~in_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] r;
		r = s;
		r = r ^ (r << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// low bits of x*y + 1 on every channel
	function automatic pixel_t pattern_pixel(input int x, input int y);
		colour_t grey;
		grey = colour_t'(x * y + 1);
		return {grey, grey, grey};
	endfunction

	task automatic value_mismatch(input string msg);
		$display("FAILED %0t ns: %s", $time, msg);
		value_errors++;
	endtask

	task automatic raster_fault(input string msg);
		$display("ERROR %0t ns: %s", $time, msg);
		raster_errors++;
	endtask

	task automatic compare_pixel(input int x, input int y);
		pixel_t exp_pix;
		exp_pix = expect_pattern ? pattern_pixel(x, y)
			: model[`VID_MEM_START_ADDR + y * H_VIS + x];
		if (out_hpix !== HPIX_BITS'(x) || out_vpix !== VPIX_BITS'(y)) begin
			value_mismatch($sformatf("position %0d,%0d but expected %0d,%0d",
				out_hpix, out_vpix, x, y));
		end
		if (out_pixel !== exp_pix) begin
			value_mismatch($sformatf("pixel %06h at %0d,%0d, expected %06h",
				out_pixel, x, y, exp_pix));
		end
		pixels_done++;
	endtask

	// random contents for the whole buffer
	task automatic build_model();
		logic [31:0] rnd;
		for (int a = 0; a < FB_WORDS; a++) begin
			rnd = next_random();
			model[a] = rnd[23:0];
		end
	endtask

	// one host write per cycle, address order keeps ahead of the raster
	task automatic fill_frame_buffer();
		for (int a = 0; a < FB_WORDS; a++) begin
			@(posedge in_clk);
			#1;
			in_wr_en = 1'b1;
			in_wr_addr = fb_addr_t'(a);
			in_wr_data = model[a];
		end
		@(posedge in_clk);
		#1;
		in_wr_en = 1'b0;
	endtask

	task automatic host_random_writes(input int count);
		logic [31:0] rnd;
		int addr;
		for (int n = 0; n < count; n++) begin
			rnd = next_random();
			repeat (rnd % 16) @(posedge in_clk);
			addr = int'(next_random() % FB_WORDS);
			rnd = next_random();
			@(posedge in_clk);
			#1;
			in_wr_en = 1'b1;
			in_wr_addr = fb_addr_t'(addr);
			in_wr_data = rnd[23:0];
			model[addr] = rnd[23:0];
			@(posedge in_clk);
			#1;
			in_wr_en = 1'b0;
		end
	endtask

	// returns 1 ns after the edge
	task automatic wait_vsync_rises(input int n);
		while (vsync_rises < n) @(posedge in_clk);
		#1;
	endtask

	// mid-cycle sampling of the outputs
	always @(negedge in_clk) begin
		if (in_rst || cycle_no < RESET_CYCLES) begin
			if (out_hsync !== 1'b0 || out_vsync !== 1'b0 || out_pixel_enable !== 1'b0
				|| out_pixel !== '0) begin
				raster_fault("outputs were not idle during or just after reset");
			end
		end
		if (!in_rst) begin
			cycle_no++;
			if (out_hsync && !prev_hsync) begin
				if (last_hs_rise >= 0 && cycle_no - last_hs_rise != H_TOTAL) begin
					raster_fault($sformatf("hsync rose %0d cycles after the last one",
						cycle_no - last_hs_rise));
				end
				last_hs_rise = cycle_no;
				hs_len = 0;
			end
			if (out_hsync) begin
				hs_len++;
			end else if (prev_hsync && hs_len != HSYNC_LEN) begin
				raster_fault($sformatf("hsync was high for %0d cycles", hs_len));
			end
			// a vsync rise closes the previous frame
			if (out_vsync && !prev_vsync) begin
				if (last_vs_rise >= 0 && cycle_no - last_vs_rise != FRAME_CYCLES) begin
					raster_fault($sformatf("vsync rose %0d cycles after the last one",
						cycle_no - last_vs_rise));
				end
				if (vsync_rises > 0) begin
					if (line_y != V_VIS) begin
						raster_fault($sformatf("frame had %0d visible lines", line_y));
					end
					frames_done++;
				end
				last_vs_rise = cycle_no;
				vsync_rises++;
				line_y = 0;
			end
			if (out_pixel_enable) begin
				if (pix_x >= H_VIS || line_y >= V_VIS) begin
					raster_fault("enabled pixel outside the visible area");
				end else begin
					compare_pixel(pix_x, line_y);
				end
				pix_x++;
			end else if (prev_en) begin
				if (pix_x != H_VIS) begin
					raster_fault($sformatf("line %0d had %0d enabled pixels", line_y, pix_x));
				end
				line_y++;
				pix_x = 0;
			end
			prev_hsync = out_hsync;
			prev_vsync = out_vsync;
			prev_en = out_pixel_enable;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int assert_fails;
		in_rst = 1'b1;
		in_testpattern = 1'b0;
		in_wr_en = 1'b0;
		in_wr_addr = '0;
		in_wr_data = '0;
		expect_pattern = 1'b0;
		rng_state = SEED;
		build_model();
		// frame 0 scans memory while the fill is still running
		fork
			begin
				repeat (RESET_CYCLES) @(posedge in_clk);
				#1;
				in_rst = 1'b0;
			end
			fill_frame_buffer();
		join
		// frame 1 shows the pattern while the host rewrites memory
		wait_vsync_rises(2);
		in_testpattern = 1'b1;
		expect_pattern = 1'b1;
		host_random_writes(NUM_WRITES);
		if (vsync_rises != 2) begin
			raster_fault("random host writes ran past the second frame");
		end
		// frame 2 shows the new contents
		wait_vsync_rises(3);
		in_testpattern = 1'b0;
		expect_pattern = 1'b0;
		wait_vsync_rises(4);
		in_testpattern = 1'b1;
		expect_pattern = 1'b1;
		wait_vsync_rises(5);
		repeat (4) @(posedge in_clk);
		if (frames_done != NUM_FRAMES) begin
			raster_fault($sformatf("only %0d whole frames were seen", frames_done));
		end
		if (pixels_done != NUM_FRAMES * H_VIS * V_VIS) begin
			raster_fault($sformatf("%0d pixels were checked", pixels_done));
		end
		assert_fails = u_video_pipe.u_checker.blank_fails
			+ u_video_pipe.u_checker.hsync_long_fails
			+ u_video_pipe.u_checker.hsync_len_fails
			+ u_video_pipe.u_checker.hpix_fails;
		$display("errors: %0d wrong values, %0d raster faults, %0d assertion failures",
			value_errors, raster_errors, assert_fails);
		if (value_errors == 0 && raster_errors == 0 && assert_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: design/frame_buffer.sv
// dual-port frame buffer

`timescale 1ns/1ns

module frame_buffer
	import video_pixel_pkg::*;
(
	input logic in_clk,

	// host write port
	input logic wr_en,
	input fb_addr_t wr_addr,
	input pixel_t wr_data,

	// scan-out read port
	input fb_addr_t rd_addr,
	output pixel_t rd_data
);

	// pixel storage, undefined until written
	pixel_t mem [FB_WORDS];

	// host writes, addresses past the frame are dropped
	always_ff @(posedge in_clk) begin
		if (wr_en && (wr_addr < fb_addr_t'(FB_WORDS))) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// synchronous read, one cycle latency
	always_ff @(posedge in_clk) begin
		if (rd_addr < fb_addr_t'(FB_WORDS)) begin
			rd_data <= mem[rd_addr];
		end else begin
			rd_data <= '0;
		end
	end

endmodule

// File: design/video_delay.sv
// alignment delay line

`timescale 1ns/1ns

module video_delay #(
	parameter type payload_t = logic,
	// cycles of delay, at least one
	parameter int DEPTH = 1
) (
	input logic in_clk,
	input logic in_rst,

	input payload_t d,
	output payload_t q
);

	// one stage per cycle, stage 0 takes the input
	payload_t stages [DEPTH];

	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else begin
			stages[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i - 1];
			end
		end
	end

	// oldest stage leaves
	assign q = stages[DEPTH - 1];

endmodule

// File: design/video_fetch.sv
// frame buffer address fetch

`timescale 1ns/1ns

`include "video_settings.svh"

module video_fetch
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
(
	input logic in_clk,
	input logic in_rst,
	input logic testpattern,

	input timing_flags_t flags_in,
	input coord_t coord_in,

	output fb_addr_t rd_addr,
	output logic pattern_sel
);

	// row start and column of the current pixel
	fb_addr_t row_base;
	fb_addr_t col_offs;

	// memory needed for this pixel?
	logic fetch_en;

	assign row_base = fb_addr_t'(coord_in.y) * fb_addr_t'(`VID_HPIX_VISIBLE);
	assign col_offs = fb_addr_t'(coord_in.x) + fb_addr_t'(`VID_MEM_START_ADDR);

	// no fetch in blanking or while the pattern is shown
	assign fetch_en = flags_in.visible && !pattern_sel;

	// row-major address, zero when idle
	always_comb begin
		rd_addr = '0;
		if (fetch_en) begin
			rd_addr = row_base + col_offs;
		end
	end

	// one sampled select value per pixel
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			pattern_sel <= 1'b0;
		end else begin
			pattern_sel <= testpattern;
		end
	end

endmodule

// File: design/video_pipe.sv
// video scan-out pipeline

`timescale 1ns/1ns

module video_pipe
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
(
	input logic in_clk,
	input logic in_rst,
	input logic in_testpattern,

	// host write port
	input logic in_wr_en,
	input fb_addr_t in_wr_addr,
	input pixel_t in_wr_data,

	// video output
	output logic out_hsync,
	output logic out_vsync,
	output logic out_pixel_enable,
	output pixel_t out_pixel,
	output logic [HPIX_BITS - 1 : 0] out_hpix,
	output logic [VPIX_BITS - 1 : 0] out_vpix
);

	// flags travel together with the sampled select
	typedef struct packed {
		timing_flags_t flags;
		logic pattern_sel;
	} flags_sel_t;

	// timing generator outputs
	timing_flags_t tg_flags;
	coord_t tg_coord;

	// fetch stage outputs
	fb_addr_t rd_addr;
	logic pattern_sel;

	// frame buffer read data
	pixel_t rd_data;

	// bundles around the alignment delay
	flags_sel_t fs_early;
	flags_sel_t fs_late;
	coord_t coord_late;

	assign fs_early.flags = tg_flags;
	assign fs_early.pattern_sel = pattern_sel;

	video_timing_gen u_timing_gen (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.flags (tg_flags),
		.coord (tg_coord)
	);

	video_fetch u_fetch (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.testpattern (in_testpattern),
		.flags_in (tg_flags),
		.coord_in (tg_coord),
		.rd_addr (rd_addr),
		.pattern_sel (pattern_sel)
	);

	frame_buffer u_frame_buffer (
		.in_clk (in_clk),
		.wr_en (in_wr_en),
		.wr_addr (in_wr_addr),
		.wr_data (in_wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// depth matches the frame buffer read latency
	video_delay #(
		.payload_t (flags_sel_t),
		.DEPTH (1)
	) u_delay_flags (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.d (fs_early),
		.q (fs_late)
	);

	video_delay #(
		.payload_t (coord_t),
		.DEPTH (1)
	) u_delay_coord (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.d (tg_coord),
		.q (coord_late)
	);

	video_pixel_out u_pixel_out (
		.in_clk (in_clk),
		.in_rst (in_rst),
		.flags (fs_late.flags),
		.coord (coord_late),
		.pattern_sel (fs_late.pattern_sel),
		.mem_pixel (rd_data),
		.hsync (out_hsync),
		.vsync (out_vsync),
		.pixel_enable (out_pixel_enable),
		.pixel (out_pixel),
		.hpix (out_hpix),
		.vpix (out_vpix)
	);

endmodule

// File: design/video_pixel_out.sv
// pixel output stage

`timescale 1ns/1ns

module video_pixel_out
	import video_timing_pkg::*;
	import video_pixel_pkg::*;
(
	input logic in_clk,
	input logic in_rst,

	input timing_flags_t flags,
	input coord_t coord,
	input logic pattern_sel,
	input pixel_t mem_pixel,

	output logic hsync,
	output logic vsync,
	output logic pixel_enable,
	output pixel_t pixel,
	output logic [HPIX_BITS - 1 : 0] hpix,
	output logic [VPIX_BITS - 1 : 0] vpix
);

	// full-width product of the coordinates
	logic [HPIX_BITS + VPIX_BITS - 1 : 0] prod;
	colour_t pat_colour;
	pixel_t pattern;
	pixel_t pixel_next;

	assign prod = coord.x * coord.y;

	// low colour bits of x*y + 1, grey on all channels
	assign pat_colour = colour_t'(prod) + 1'b1;
	assign pattern = {3{pat_colour}};

	// source select, black in blanking
	always_comb begin
		pixel_next = '0;
		if (flags.visible) begin
			pixel_next = pattern_sel ? pattern : mem_pixel;
		end
	end

	// everything leaving the chip is registered
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			hsync <= 1'b0;
			vsync <= 1'b0;
			pixel_enable <= 1'b0;
			pixel <= '0;
			hpix <= '0;
			vpix <= '0;
		end else begin
			hsync <= flags.hsync;
			vsync <= flags.vsync;
			pixel_enable <= flags.visible;
			pixel <= pixel_next;
			hpix <= coord.x;
			vpix <= coord.y;
		end
	end

endmodule

// File: design/video_pixel_pkg.sv
// pixel and memory types

`include "video_settings.svh"

package video_pixel_pkg;

	// one colour channel
	typedef logic [`VID_COLOUR_BITS - 1 : 0] colour_t;

	// three channels, red in the top bits
	typedef struct packed {
		colour_t r;
		colour_t g;
		colour_t b;
	} pixel_t;

	// words needed for one visible frame plus the base offset
	localparam int FB_WORDS =
		`VID_HPIX_VISIBLE * `VID_VPIX_VISIBLE + `VID_MEM_START_ADDR;
	localparam int FB_ADDR_BITS = $clog2(FB_WORDS);

	typedef logic [FB_ADDR_BITS - 1 : 0] fb_addr_t;

endpackage

// File: design/video_settings.svh
// video mode settings

`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// bits per colour channel
`define VID_COLOUR_BITS 8

// horizontal timing, in pixel clocks from line start
`define VID_HSYNC_START 4
`define VID_HSYNC_STOP 12
// first visible column
`define VID_HSYNC_DELAY 24
`define VID_HPIX_VISIBLE 64
`define VID_HPIX_TOTAL (`VID_HPIX_VISIBLE + `VID_HSYNC_DELAY)

// vertical timing, in lines from frame start
`define VID_VSYNC_START 2
`define VID_VSYNC_STOP 4
// first visible line
`define VID_VSYNC_DELAY 8
`define VID_VPIX_VISIBLE 48
`define VID_VPIX_TOTAL (`VID_VPIX_VISIBLE + `VID_VSYNC_DELAY)

// base of the displayed frame in the buffer
`define VID_MEM_START_ADDR 0

`endif

// File: design/video_timing_gen.sv
// raster timing generator

`timescale 1ns/1ns

`include "video_settings.svh"

module video_timing_gen
	import video_timing_pkg::*;
(
	input logic in_clk,
	input logic in_rst,

	output timing_flags_t flags,
	output coord_t coord
);

	// raster position, whole line and frame
	hctr_t h_ctr;
	vctr_t v_ctr;

	// position for the coming cycle
	hctr_t h_next;
	vctr_t v_next;

	logic h_wrap;
	logic v_wrap;

	// decode of the coming position
	logic hsync_next;
	logic vsync_next;
	logic visible_next;

	assign h_wrap = (h_ctr == hctr_t'(`VID_HPIX_TOTAL - 1));
	assign v_wrap = (v_ctr == vctr_t'(`VID_VPIX_TOTAL - 1));

	// horizontal count wraps at the line end
	assign h_next = h_wrap ? '0 : h_ctr + 1'b1;

	// vertical count only steps at the line end
	always_comb begin
		v_next = v_ctr;
		if (h_wrap) begin
			v_next = v_wrap ? '0 : v_ctr + 1'b1;
		end
	end

	// sync windows
	assign hsync_next = (h_next >= hctr_t'(`VID_HSYNC_START))
		&& (h_next < hctr_t'(`VID_HSYNC_STOP));
	assign vsync_next = (v_next >= vctr_t'(`VID_VSYNC_START))
		&& (v_next < vctr_t'(`VID_VSYNC_STOP));

	// visible window follows the blanking delay
	assign visible_next = (h_next >= hctr_t'(`VID_HSYNC_DELAY))
		&& (v_next >= vctr_t'(`VID_VSYNC_DELAY));

	// counters
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			h_ctr <= '0;
			v_ctr <= '0;
		end else begin
			h_ctr <= h_next;
			v_ctr <= v_next;
		end
	end

	// registered decode, level with the count
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			flags <= '0;
			coord <= '0;
		end else begin
			flags.hsync <= hsync_next;
			flags.vsync <= vsync_next;
			flags.visible <= visible_next;
			// coordinates stay zero in blanking
			if (visible_next) begin
				coord.x <= HPIX_BITS'(h_next - hctr_t'(`VID_HSYNC_DELAY));
				coord.y <= VPIX_BITS'(v_next - vctr_t'(`VID_VSYNC_DELAY));
			end else begin
				coord <= '0;
			end
		end
	end

endmodule

// File: design/video_timing_pkg.sv
// raster timing types

`include "video_settings.svh"

package video_timing_pkg;

	// widths of raster and visible counters
	localparam int HCTR_BITS = $clog2(`VID_HPIX_TOTAL);
	localparam int VCTR_BITS = $clog2(`VID_VPIX_TOTAL);
	localparam int HPIX_BITS = $clog2(`VID_HPIX_VISIBLE);
	localparam int VPIX_BITS = $clog2(`VID_VPIX_VISIBLE);

	typedef logic [HCTR_BITS - 1 : 0] hctr_t;
	typedef logic [VCTR_BITS - 1 : 0] vctr_t;

	// sync and visible-area flags of one raster position
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic visible;
	} timing_flags_t;

	// position inside the visible area
	typedef struct packed {
		logic [HPIX_BITS - 1 : 0] x;
		logic [VPIX_BITS - 1 : 0] y;
	} coord_t;

endpackage

// File: video_pipe.f
+incdir+design
design/video_timing_pkg.sv
design/video_pixel_pkg.sv
design/video_timing_gen.sv
design/video_fetch.sv
design/frame_buffer.sv
design/video_delay.sv
design/video_pixel_out.sv
design/video_pipe.sv
bench/video_pipe_checker.sv
bench/video_pipe_tb.sv
